// File: include/rename_params.svh
//--------------------------------------------------
// Rename parameters
// Group width, architectural register count and
// reorder buffer depth shared by the rename block
//--------------------------------------------------

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Operations accepted from decode per cycle
`define PIPE_WIDTH 2

// Integer architectural registers, x0 included
`define NUM_ARCH_REGS 32

// Tags in flight
// Must stay a power of two so tag pointers wrap for free
`define ROB_DEPTH 16

`endif

// File: design/isa_pkg.sv
//--------------------------------------------------
// ISA package
// Architectural register index, operation classes
// and the operand usage of each class
//--------------------------------------------------

`include "rename_params.svh"

package isa_pkg;

    // Architectural register index
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

    // Operation class as seen by rename
    typedef enum logic [2:0] {
        op_alu     = 3'd0,
        op_alu_imm = 3'd1,
        op_load    = 3'd2,
        op_store   = 3'd3,
        op_branch  = 3'd4
    } opcode_e;

    // Stores and branches have no destination
    function automatic logic op_writes_rd(opcode_e op);
        return !(op inside {op_store, op_branch});
    endfunction

    // Immediate forms and loads take no second source
    function automatic logic op_uses_rs2(opcode_e op);
        return op inside {op_alu, op_store, op_branch};
    endfunction

endpackage

// File: design/uarch_pkg.sv
//--------------------------------------------------
// Microarchitecture package
// Reorder buffer tag and occupancy count types
//--------------------------------------------------

`include "rename_params.svh"

package uarch_pkg;

    // Reorder buffer tag, one per operation in flight
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // Occupancy, one bit wider so a full ring is representable
    typedef logic [$clog2(`ROB_DEPTH):0] tag_count_t;

endpackage

// File: design/rename_map_table.sv
//--------------------------------------------------
// Register alias table
// Holds a renamed bit and producer tag per register
// Four lookup ports, two speculative writes, two
// tag-matched commit clears and a total flush
//--------------------------------------------------

`timescale 1ns/100ps

`include "rename_params.svh"

module rename_map_table (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    flush,
    // Lookups, slot 0 rs1 and rs2 first, then slot 1
    input  isa_pkg::arch_reg_t  [3:0]               rd_addr,
    output logic                [3:0]               rd_renamed,
    output uarch_pkg::rob_tag_t [3:0]               rd_tag,
    // Speculative writes from rename
    input  logic                [`PIPE_WIDTH-1:0]   wr_en,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]   wr_addr,
    input  uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]   wr_tag,
    // In-order commits
    input  logic                [`PIPE_WIDTH-1:0]   cmt_valid,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]   cmt_rd,
    input  uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]   cmt_tag
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic [`NUM_ARCH_REGS-1:0]  renamed_q;
    rob_tag_t                   tag_q [`NUM_ARCH_REGS];

    // Per register events this cycle
    logic [`NUM_ARCH_REGS-1:0]  wr_hit;
    logic [`NUM_ARCH_REGS-1:0]  cmt_hit;

    //--------------------------------------------------
    // Update decode
    //--------------------------------------------------
    always_comb begin
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            wr_hit[r]  = 1'b0;
            cmt_hit[r] = 1'b0;
            for (int s = 0; s < `PIPE_WIDTH; s++) begin
                if (wr_en[s] && wr_addr[s] == arch_reg_t'(r)) begin
                    wr_hit[r] = 1'b1;
                end
                // Clear only if no younger producer took the entry over
                if (cmt_valid[s] && cmt_rd[s] == arch_reg_t'(r) && renamed_q[r] &&
                    tag_q[r] == cmt_tag[s]) begin
                    cmt_hit[r] = 1'b1;
                end
            end
        end
    end

    // Renamed bits, writes override clears
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            renamed_q <= '0;
        end else begin
            renamed_q <= (renamed_q & ~cmt_hit) | wr_hit;
        end
    end

    // Producer tags
    // Slot 1 is applied last so it wins a same-register collision
    always_ff @(posedge clk) begin
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            if (wr_en[s]) begin
                tag_q[wr_addr[s]] <= wr_tag[s];
            end
        end
    end

    //--------------------------------------------------
    // Lookup
    //--------------------------------------------------
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            // x0 is hardwired, never a dependency
            rd_renamed[p] = (rd_addr[p] != '0) && renamed_q[rd_addr[p]];
            rd_tag[p]     = rd_renamed[p] ? tag_q[rd_addr[p]] : '0;
        end
    end

    // The stage never allocates x0, so no commit can find it renamed
    a_no_x0_clear: assert property (@(posedge clk) disable iff (rst) !cmt_hit[0])
        else $error("commit cleared alias entry of register 0");

endmodule

// File: design/rob_tag_alloc.sv
//--------------------------------------------------
// ROB tag allocator
// Circular in-order ring of tags tracked by tail
// and occupancy; grants up to two tags per cycle,
// all or nothing, and frees tags on commit
//--------------------------------------------------

`timescale 1ns/100ps

`include "rename_params.svh"

module rob_tag_alloc (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    flush,
    input  logic                [`PIPE_WIDTH-1:0]   alloc_req,
    input  logic                                    fire,
    output logic                [`PIPE_WIDTH-1:0]   alloc_gnt,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]   alloc_tags,
    input  logic                [`PIPE_WIDTH-1:0]   cmt_valid,
    output uarch_pkg::tag_count_t                   free_count
);
    import uarch_pkg::*;

    // Next tag to hand out
    rob_tag_t   tail_q;
    // Tags in flight
    // Oldest one sits at tail minus occupancy
    tag_count_t count_q;

    tag_count_t n_req;
    tag_count_t n_gnt;
    tag_count_t n_alloc;
    tag_count_t n_cmt;
    logic       grant_ok;

    always_comb begin
        n_req = '0;
        n_gnt = '0;
        n_cmt = '0;
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            n_req = n_req + tag_count_t'(alloc_req[s]);
            n_gnt = n_gnt + tag_count_t'(alloc_gnt[s]);
            n_cmt = n_cmt + tag_count_t'(cmt_valid[s]);
        end
    end

    assign free_count = tag_count_t'(`ROB_DEPTH) - count_q;
    assign grant_ok   = free_count >= n_req;
    assign alloc_gnt  = grant_ok ? alloc_req : '0;
    assign n_alloc    = fire ? n_gnt : '0;

    // Tags in slot order from the tail, idle slots skip no tag
    always_comb begin
        rob_tag_t next_tag;
        next_tag = tail_q;
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            alloc_tags[s] = next_tag;
            next_tag      = next_tag + rob_tag_t'(alloc_req[s]);
        end
    end

    //--------------------------------------------------
    // Ring state
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q  <= tail_q + rob_tag_t'(n_alloc);
            count_q <= count_q + n_alloc - n_cmt;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count_q <= tag_count_t'(`ROB_DEPTH))
        else $error("tag ring occupancy above depth");

    // Commit side must never retire more than is in flight
    a_no_empty_commit: assert property (@(posedge clk) disable iff (rst)
        (|cmt_valid) |-> (n_cmt <= count_q))
        else $error("commit while tag ring empty");

endmodule

// File: design/rename_stage.sv
//--------------------------------------------------
// Rename stage
// Looks up sources, takes tags from the allocator,
// forwards slot 0's destination to slot 1, compacts
// a lone op into slot 0 and registers the group
// behind a ready/valid handshake to dispatch
//--------------------------------------------------

`timescale 1ns/100ps

`include "rename_params.svh"

module rename_stage (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            flush,
    // Decode
    input  logic                [`PIPE_WIDTH-1:0]           dec_valid,
    output logic                                            dec_ready,
    input  isa_pkg::opcode_e    [`PIPE_WIDTH-1:0]           dec_opcode,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           dec_rd,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           dec_rs1,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           dec_rs2,
    input  logic                [`PIPE_WIDTH-1:0][31:0]     dec_pc,
    // Dispatch
    output logic                [`PIPE_WIDTH-1:0]           out_valid,
    input  logic                                            out_ready,
    output isa_pkg::opcode_e    [`PIPE_WIDTH-1:0]           out_opcode,
    output logic                [`PIPE_WIDTH-1:0][31:0]     out_pc,
    output isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           out_rd,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           out_tag,
    output logic                [`PIPE_WIDTH-1:0]           out_rs1_renamed,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           out_rs1_tag,
    output logic                [`PIPE_WIDTH-1:0]           out_rs2_renamed,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           out_rs2_tag,
    // Tag allocator
    output logic                [`PIPE_WIDTH-1:0]           alloc_req,
    input  logic                [`PIPE_WIDTH-1:0]           alloc_gnt,
    input  uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           alloc_tags,
    output logic                                            fire,
    // Alias table
    output isa_pkg::arch_reg_t  [3:0]                       rd_addr,
    input  logic                [3:0]                       rd_renamed,
    input  uarch_pkg::rob_tag_t [3:0]                       rd_tag,
    output logic                [`PIPE_WIDTH-1:0]           wr_en,
    output isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           wr_addr,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           wr_tag
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic     [`PIPE_WIDTH-1:0] writes_rd;
    logic     [`PIPE_WIDTH-1:0] rs1_ren;
    logic     [`PIPE_WIDTH-1:0] rs2_ren;
    rob_tag_t [`PIPE_WIDTH-1:0] rs1_tag;
    rob_tag_t [`PIPE_WIDTH-1:0] rs2_tag;
    logic                       out_free;

    //--------------------------------------------------
    // Handshake
    //--------------------------------------------------
    assign alloc_req = dec_valid;
    // Output slot empties this edge, or is empty already
    assign out_free  = !(|out_valid) || out_ready;
    assign dec_ready = out_free && ((alloc_gnt & dec_valid) == dec_valid);
    assign fire      = (|dec_valid) && dec_ready;

    // Raw source indices straight to the table
    assign rd_addr = {dec_rs2[1], dec_rs1[1], dec_rs2[0], dec_rs1[0]};

    always_comb begin
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            writes_rd[s] = op_writes_rd(dec_opcode[s]) && (dec_rd[s] != '0);
        end
    end

    // New mappings, table resolves slot 1 over slot 0
    assign wr_en   = {`PIPE_WIDTH{fire}} & dec_valid & writes_rd;
    assign wr_addr = dec_rd;
    assign wr_tag  = alloc_tags;

    //--------------------------------------------------
    // Source renaming
    //--------------------------------------------------
    always_comb begin
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            rs1_ren[s] = rd_renamed[2*s];
            rs1_tag[s] = rd_tag[2*s];
            // Unused second source reads as architectural
            rs2_ren[s] = op_uses_rs2(dec_opcode[s]) && rd_renamed[2*s+1];
            rs2_tag[s] = rs2_ren[s] ? rd_tag[2*s+1] : '0;
        end
        // Intra-group dependency, table still holds the old mapping
        if (dec_valid[0] && writes_rd[0]) begin
            if (dec_rs1[1] == dec_rd[0]) begin
                rs1_ren[1] = 1'b1;
                rs1_tag[1] = alloc_tags[0];
            end
            if (op_uses_rs2(dec_opcode[1]) && dec_rs2[1] == dec_rd[0]) begin
                rs2_ren[1] = 1'b1;
                rs2_tag[1] = alloc_tags[0];
            end
        end
    end

    //--------------------------------------------------
    // Compaction and output register
    //--------------------------------------------------
    logic shift;

    // Lone slot 1 moves down to slot 0
    assign shift = !dec_valid[0] && dec_valid[1];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= '0;
        end else if (out_free) begin
            out_valid <= fire ? (shift ? 2'b01 : dec_valid) : '0;
        end
    end

    // Payload, slot 1 contents are don't-care when shifted
    always_ff @(posedge clk) begin
        if (fire) begin
            out_opcode[0]      <= dec_opcode[shift];
            out_pc[0]          <= dec_pc[shift];
            out_rd[0]          <= dec_rd[shift];
            out_tag[0]         <= alloc_tags[shift];
            out_rs1_renamed[0] <= rs1_ren[shift];
            out_rs1_tag[0]     <= rs1_tag[shift];
            out_rs2_renamed[0] <= rs2_ren[shift];
            out_rs2_tag[0]     <= rs2_tag[shift];

            out_opcode[1]      <= dec_opcode[1];
            out_pc[1]          <= dec_pc[1];
            out_rd[1]          <= dec_rd[1];
            out_tag[1]         <= alloc_tags[1];
            out_rs1_renamed[1] <= rs1_ren[1];
            out_rs1_tag[1]     <= rs1_tag[1];
            out_rs2_renamed[1] <= rs2_ren[1];
            out_rs2_tag[1]     <= rs2_tag[1];
        end
    end

    // Dispatch relies on slot 0 holding the oldest op
    a_compacted: assert property (@(posedge clk) disable iff (rst)
        out_valid[1] |-> out_valid[0])
        else $error("output slot 1 valid without slot 0");

endmodule

// File: design/rename_top.sv
//--------------------------------------------------
// Rename block top level
// Rename stage with its alias table and ROB tag
// allocator, commit ports shared by both
//--------------------------------------------------

`timescale 1ns/100ps

`include "rename_params.svh"

module rename_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            flush,
    // Decode
    input  logic                [`PIPE_WIDTH-1:0]           dec_valid,
    output logic                                            dec_ready,
    input  isa_pkg::opcode_e    [`PIPE_WIDTH-1:0]           dec_opcode,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           dec_rd,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           dec_rs1,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           dec_rs2,
    input  logic                [`PIPE_WIDTH-1:0][31:0]     dec_pc,
    // Dispatch
    output logic                [`PIPE_WIDTH-1:0]           out_valid,
    input  logic                                            out_ready,
    output isa_pkg::opcode_e    [`PIPE_WIDTH-1:0]           out_opcode,
    output logic                [`PIPE_WIDTH-1:0][31:0]     out_pc,
    output isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           out_rd,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           out_tag,
    output logic                [`PIPE_WIDTH-1:0]           out_rs1_renamed,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           out_rs1_tag,
    output logic                [`PIPE_WIDTH-1:0]           out_rs2_renamed,
    output uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           out_rs2_tag,
    // Commit
    input  logic                [`PIPE_WIDTH-1:0]           cmt_valid,
    input  isa_pkg::arch_reg_t  [`PIPE_WIDTH-1:0]           cmt_rd,
    input  uarch_pkg::rob_tag_t [`PIPE_WIDTH-1:0]           cmt_tag
);
    import isa_pkg::*;
    import uarch_pkg::*;

    // Stage to allocator
    logic       [`PIPE_WIDTH-1:0]   alloc_req;
    logic       [`PIPE_WIDTH-1:0]   alloc_gnt;
    rob_tag_t   [`PIPE_WIDTH-1:0]   alloc_tags;
    logic                           fire;

    // Stage to alias table
    arch_reg_t  [3:0]               rd_addr;
    logic       [3:0]               rd_renamed;
    rob_tag_t   [3:0]               rd_tag;
    logic       [`PIPE_WIDTH-1:0]   wr_en;
    arch_reg_t  [`PIPE_WIDTH-1:0]   wr_addr;
    rob_tag_t   [`PIPE_WIDTH-1:0]   wr_tag;

    rename_stage rename_stage_i (.*);

    rename_map_table rename_map_table_i (.*);

    // Occupancy reaches the stage only through the grants
    rob_tag_alloc rob_tag_alloc_i (
        .free_count (),
        .*
    );

endmodule

// File: verif/rename_tb.sv
//--------------------------------------------------
// Rename block testbench
// Replays decode groups, commits and flushes from a
// vector file and checks every cycle against a model
// of the alias table, tag ring and output register
//--------------------------------------------------

`timescale 1ns/100ps

`include "rename_params.svh"

module rename_tb;
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int MAX_WAIT = 64;

    logic                           clk;
    logic                           rst;
    logic                           flush;
    logic       [`PIPE_WIDTH-1:0]   dec_valid;
    logic                           dec_ready;
    opcode_e    [`PIPE_WIDTH-1:0]   dec_opcode;
    arch_reg_t  [`PIPE_WIDTH-1:0]   dec_rd;
    arch_reg_t  [`PIPE_WIDTH-1:0]   dec_rs1;
    arch_reg_t  [`PIPE_WIDTH-1:0]   dec_rs2;
    logic       [`PIPE_WIDTH-1:0][31:0] dec_pc;
    logic       [`PIPE_WIDTH-1:0]   out_valid;
    logic                           out_ready;
    opcode_e    [`PIPE_WIDTH-1:0]   out_opcode;
    logic       [`PIPE_WIDTH-1:0][31:0] out_pc;
    arch_reg_t  [`PIPE_WIDTH-1:0]   out_rd;
    rob_tag_t   [`PIPE_WIDTH-1:0]   out_tag;
    logic       [`PIPE_WIDTH-1:0]   out_rs1_renamed;
    rob_tag_t   [`PIPE_WIDTH-1:0]   out_rs1_tag;
    logic       [`PIPE_WIDTH-1:0]   out_rs2_renamed;
    rob_tag_t   [`PIPE_WIDTH-1:0]   out_rs2_tag;
    logic       [`PIPE_WIDTH-1:0]   cmt_valid;
    arch_reg_t  [`PIPE_WIDTH-1:0]   cmt_rd;
    rob_tag_t   [`PIPE_WIDTH-1:0]   cmt_tag;

    rename_top rename_top_i (.*);

    //--------------------------------------------------
    // Reference model, owned by the monitor
    //--------------------------------------------------
    logic           m_ren [`NUM_ARCH_REGS];
    int             m_tag [`NUM_ARCH_REGS];
    int             m_tail;
    int             m_count;
    logic           m_full;
    logic           m_ready;
    logic [1:0]     m_valid;
    // Tags in flight, oldest first, with the register each one maps
    int             fly_tag [$];
    int             fly_rd [$];
    // Expected contents of the output register, compacted
    int             e_op [2];
    int             e_rd [2];
    int             e_tag [2];
    logic [31:0]    e_pc [2];
    logic           e_r1 [2];
    int             e_t1 [2];
    logic           e_r2 [2];
    int             e_t2 [2];

    int             err_count = 0;
    int             check_count = 0;
    int             fire_count = 0;

    // Current vector, written by the driver only
    logic [1:0]     vec_valid;
    int             vec_op [2];
    int             vec_rd [2];
    int             vec_rs1 [2];
    int             vec_rs2 [2];
    int             vec_cmt;
    int             vec_flush;
    logic [31:0]    pc_next;
    int             seed = 85;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Stores and branches have no destination, x0 is never renamed
    function automatic bit has_dest(int op, int rd);
        return op != int'(op_store) && op != int'(op_branch) && rd != 0;
    endfunction

    // Immediate ALU ops and loads have no second source
    function automatic bit reads_rs2(int op);
        return op == int'(op_alu) || op == int'(op_store) || op == int'(op_branch);
    endfunction

    task automatic compare(input string field, input int slot, input logic [31:0] got,
                           input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH at %0t: %s slot %0d got %0h expected %0h",
                     $time, field, slot, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            m_ren[r] = 1'b0;
            m_tag[r] = 0;
        end
        m_tail  = 0;
        m_count = 0;
        m_full  = 1'b0;
        m_valid = 2'b00;
        fly_tag.delete();
        fly_rd.delete();
    endtask

    task automatic check_outputs();
        int n_req;
        n_req   = int'(dec_valid[0]) + int'(dec_valid[1]);
        m_ready = (!m_full || out_ready) && (`ROB_DEPTH - m_count >= n_req);
        compare("dec_ready", 0, 32'(dec_ready), 32'(m_ready));
        compare("out_valid", 0, 32'(out_valid), 32'(m_valid));
        for (int s = 0; s < 2; s++) begin
            if (m_valid[s]) begin
                compare("out_opcode", s, 32'(out_opcode[s]), 32'(e_op[s]));
                compare("out_pc", s, out_pc[s], e_pc[s]);
                compare("out_rd", s, 32'(out_rd[s]), 32'(e_rd[s]));
                compare("out_tag", s, 32'(out_tag[s]), 32'(e_tag[s]));
                compare("out_rs1_renamed", s, 32'(out_rs1_renamed[s]), 32'(e_r1[s]));
                compare("out_rs1_tag", s, 32'(out_rs1_tag[s]), 32'(e_t1[s]));
                compare("out_rs2_renamed", s, 32'(out_rs2_renamed[s]), 32'(e_r2[s]));
                compare("out_rs2_tag", s, 32'(out_rs2_tag[s]), 32'(e_t2[s]));
            end
        end
    endtask

    // Advance the model across the coming rising edge
    task automatic step_model();
        int rs1;
        int rs2;
        int op;
        int rd;
        int pos;
        logic fire;
        if (flush) begin
            reset_model();
            return;
        end
        fire = (dec_valid != 2'b00) && m_ready;
        pos  = 0;
        // Rename from the table as it stands before this edge
        if (fire) begin
            for (int s = 0; s < 2; s++) begin
                if (dec_valid[s]) begin
                    op  = int'(dec_opcode[s]);
                    rs1 = int'(dec_rs1[s]);
                    rs2 = int'(dec_rs2[s]);
                    e_op[pos]  = op;
                    e_pc[pos]  = dec_pc[s];
                    e_rd[pos]  = int'(dec_rd[s]);
                    e_tag[pos] = (m_tail + pos) % `ROB_DEPTH;
                    e_r1[pos]  = rs1 != 0 && m_ren[rs1];
                    e_t1[pos]  = e_r1[pos] ? m_tag[rs1] : 0;
                    e_r2[pos]  = reads_rs2(op) && rs2 != 0 && m_ren[rs2];
                    e_t2[pos]  = e_r2[pos] ? m_tag[rs2] : 0;
                    // Slot 0 result is newer than anything in the table
                    if (pos == 1 && has_dest(e_op[0], e_rd[0])) begin
                        if (rs1 == e_rd[0]) begin
                            e_r1[1] = 1'b1;
                            e_t1[1] = e_tag[0];
                        end
                        if (reads_rs2(op) && rs2 == e_rd[0]) begin
                            e_r2[1] = 1'b1;
                            e_t2[1] = e_tag[0];
                        end
                    end
                    pos++;
                end
            end
            fire_count++;
        end
        // Commits clear only a still-matching mapping
        for (int s = 0; s < 2; s++) begin
            if (cmt_valid[s]) begin
                rd = int'(cmt_rd[s]);
                if (rd != 0 && m_ren[rd] && m_tag[rd] == int'(cmt_tag[s])) begin
                    m_ren[rd] = 1'b0;
                end
                void'(fly_tag.pop_front());
                void'(fly_rd.pop_front());
                m_count--;
            end
        end
        // New mappings after clears, slot 1 last
        for (int j = 0; j < pos; j++) begin
            if (has_dest(e_op[j], e_rd[j])) begin
                m_ren[e_rd[j]] = 1'b1;
                m_tag[e_rd[j]] = e_tag[j];
            end
            fly_tag.push_back(e_tag[j]);
            fly_rd.push_back(has_dest(e_op[j], e_rd[j]) ? e_rd[j] : 0);
            m_tail  = (m_tail + 1) % `ROB_DEPTH;
            m_count++;
        end
        if (!m_full || out_ready) begin
            m_full  = fire;
            m_valid = !fire ? 2'b00 : (pos == 2) ? 2'b11 : 2'b01;
        end
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            check_outputs();
            step_model();
        end
    end

    //--------------------------------------------------
    // Driver
    //--------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
        // Dispatch takes a group three cycles in four
        out_ready = ($random(seed) & 3) != 0;
    endtask

    task automatic flush_cycle();
        // Dispatch held off so only the flush can empty the output register
        out_ready = 1'b0;
        flush     = 1'b1;
        next_cycle();
        flush = 1'b0;
    endtask

    // Present the group and retire the oldest tags in the same cycles
    task automatic apply_vector(input int idx, output bit failed);
        int left;
        int k;
        int waited;
        int fires;
        bit pending;
        failed  = 1'b0;
        left    = vec_cmt;
        pending = vec_valid != 2'b00;
        waited  = 0;
        fires   = fire_count;
        for (int s = 0; s < 2; s++) begin
            dec_opcode[s] = opcode_e'(vec_op[s]);
            dec_rd[s]     = arch_reg_t'(vec_rd[s]);
            dec_rs1[s]    = arch_reg_t'(vec_rs1[s]);
            dec_rs2[s]    = arch_reg_t'(vec_rs2[s]);
            dec_pc[s]     = pc_next + 32'(4 * s);
        end
        dec_valid = vec_valid;
        while (!failed && (pending || left > 0)) begin
            k = (left < 2) ? left : 2;
            if (k > fly_tag.size()) begin
                k = fly_tag.size();
            end
            if (k == 0) begin
                left = 0;
            end
            cmt_valid = 2'b00;
            for (int j = 0; j < k; j++) begin
                cmt_valid[j] = 1'b1;
                cmt_tag[j]   = rob_tag_t'(fly_tag[j]);
                cmt_rd[j]    = arch_reg_t'(fly_rd[j]);
            end
            left = left - k;
            next_cycle();
            cmt_valid = 2'b00;
            if (fire_count != fires) begin
                pending   = 1'b0;
                dec_valid = 2'b00;
            end
            waited++;
            if ((pending || left > 0) && waited > MAX_WAIT) begin
                $display("timeout waiting for dec_ready on vector %0d", idx);
                failed = 1'b1;
            end
        end
        dec_valid = 2'b00;
        pc_next   = pc_next + 32'd8;
    endtask

    initial begin
        int fd;
        int n;
        int test_id;
        int cur_test;
        int n_tests;
        int test_vecs;
        int test_errs;
        int vec_count;
        int waited;
        bit aborted;
        string line;
        cur_test  = 0;
        n_tests   = 0;
        test_vecs = 0;
        test_errs = 0;
        vec_count = 0;
        pc_next   = 32'h0000_1000;
        rst       = 1'b1;
        flush     = 1'b0;
        dec_valid = 2'b00;
        out_ready = 1'b1;
        cmt_valid = 2'b00;
        for (int s = 0; s < 2; s++) begin
            dec_opcode[s] = op_alu;
            dec_rd[s]     = '0;
            dec_rs1[s]    = '0;
            dec_rs2[s]    = '0;
            dec_pc[s]     = '0;
            cmt_rd[s]     = '0;
            cmt_tag[s]    = '0;
        end
        repeat (3) next_cycle();
        rst = 1'b0;

        fd      = $fopen("verif/rename_vectors.txt", "r");
        aborted = (fd == 0);
        if (aborted) begin
            $display("could not open the vector file verif/rename_vectors.txt");
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%d %b %d %d %d %d %d %d %d %d %d %d", test_id, vec_valid,
                        vec_op[0], vec_rd[0], vec_rs1[0], vec_rs2[0],
                        vec_op[1], vec_rd[1], vec_rs1[1], vec_rs2[1], vec_cmt, vec_flush);
            // Comment and blank lines do not scan
            if (n == 12) begin
                if (test_id != cur_test) begin
                    if (cur_test != 0) begin
                        $display("test %0d: %0d vectors, %0d errors",
                                 cur_test, test_vecs, err_count - test_errs);
                    end
                    cur_test  = test_id;
                    test_vecs = 0;
                    test_errs = err_count;
                    n_tests++;
                end
                vec_count++;
                test_vecs++;
                if (vec_flush != 0) begin
                    flush_cycle();
                end
                apply_vector(vec_count, aborted);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Let dispatch take the last group
        waited = 0;
        while (!aborted && m_full) begin
            next_cycle();
            waited++;
            if (m_full && waited > MAX_WAIT) begin
                $display("timeout waiting for the output register to drain");
                aborted = 1'b1;
            end
        end
        if (cur_test != 0) begin
            $display("test %0d: %0d vectors, %0d errors",
                     cur_test, test_vecs, err_count - test_errs);
        end
        $display("%0d tests, %0d vectors, %0d checks, %0d errors",
                 n_tests, vec_count, check_count, err_count);
        if (!aborted && err_count == 0 && check_count > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/rename_vectors.txt
# test valid op0 rd0 rs1_0 rs2_0 op1 rd1 rs1_1 rs2_1 commits flush
# op: 0 alu, 1 alu_imm, 2 load, 3 store, 4 branch; valid is binary, slot 1 on the left
1 11 0 1 2 3 0 4 5 6 0 0
1 11 2 7 8 0 1 9 10 0 0 0
1 01 0 11 12 13 0 0 0 0 0 0
2 11 0 5 1 4 0 6 5 5 0 0
2 11 0 0 0 0 0 8 0 0 0 0
2 11 3 9 9 6 0 10 9 9 0 0
2 11 1 12 6 8 2 13 12 12 0 0
3 10 0 0 0 0 0 14 1 4 0 0
3 10 0 0 0 0 4 0 14 5 0 0
4 01 0 15 14 1 0 0 0 0 0 0
4 11 0 16 15 16 0 17 16 15 3 0
4 11 0 18 17 16 0 19 18 17 2 0
5 11 0 20 0 0 0 20 0 0 2 0
5 01 0 21 20 20 0 0 0 0 2 0
5 00 0 0 0 0 0 0 0 0 12 0
5 11 0 24 20 12 0 25 21 16 0 0
5 00 0 0 0 0 0 0 0 0 2 0
5 11 0 26 20 21 0 27 24 25 0 0
5 01 0 24 24 0 0 0 0 0 1 0
5 01 0 1 24 25 0 0 0 0 0 0
5 11 4 0 24 26 3 0 27 24 4 0
6 11 0 2 24 25 0 3 2 26 0 0
6 00 0 0 0 0 0 0 0 0 0 1
6 11 0 4 24 25 0 5 26 27 0 0
6 01 0 6 4 5 0 0 0 0 2 0
6 11 0 8 9 10 0 9 8 4 0 0
6 00 0 0 0 0 0 0 0 0 0 1
6 11 0 7 6 4 0 8 7 6 0 0
6 10 0 0 0 0 0 9 7 8 0 0

// File: filelist.f
+incdir+include
design/isa_pkg.sv
design/uarch_pkg.sv
design/rename_map_table.sv
design/rob_tag_alloc.sv
design/rename_stage.sv
design/rename_top.sv
verif/rename_tb.sv

// File: Makefile
# Verilator build and run for the rename block

VERILATOR ?= verilator
TOP       ?= rename_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
